/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // ########################################
    // memory sizes in 32-bit words
    // ########################################

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 64;

    // ########################################
    // instruction encodings
    // ########################################

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // function field of R-type instructions
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOpT;

    // ########################################
    // control and observation structs
    // ########################################

    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        logic  zeroExt;
        logic  memToReg;
        logic  regWrite;
        logic  memWrite;
        logic  branch;
        logic  jump;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } regCommitT;

    // addr is a byte address, as computed by the ALU
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic [31:0] data;
    } memCommitT;

    typedef struct packed {
        logic        en;
        logic [7:0]  addr;
        logic [31:0] data;
    } imemLoadT;

endpackage

`default_nettype wire

/* design/pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module pcUnit import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic [31:0] inst,
    input  wire ctrlT        ctrl,
    input  wire logic        zero,
    output logic [31:0]      pc
);

    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // jump keeps the 256MB region of the delay-slot address
    assign jumpTarget = {pcPlus4[31:28], inst[25:0], 2'b00};

    always_comb begin
        nextPc = pcPlus4;
        if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && zero) begin
            nextPc = branchTarget;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* design/instrMem.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMem import mipsPkg::*; (
    input  wire logic        clk,
    input  wire imemLoadT    imemLoad,
    input  wire logic [31:0] pc,
    output logic [31:0]      inst
);

    logic [31:0] mem [IMEM_DEPTH];
    logic [7:0]  fetchIdx;

    // program words are written only while the core sits in reset
    always_ff @(posedge clk) begin
        if (imemLoad.en) begin
            mem[imemLoad.addr] <= imemLoad.data;
        end
    end

    // byte address to word index, anything above bit 9 wraps
    assign fetchIdx = pc[9:2];
    assign inst     = mem[fetchIdx];

endmodule

`default_nettype wire

/* design/controlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecode import mipsPkg::*; (
    input  wire logic [31:0] inst,
    output ctrlT             ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        // anything not matched below falls through as a nop
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        unique case (opcode)
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_ORI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_OR;
            end
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BEQ: begin
                // the subtract drives the zero flag used by pcUnit
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic [31:0] inst,
    input  wire ctrlT        ctrl,
    input  wire logic [31:0] writeData,
    output logic [31:0]      rsData,
    output logic [31:0]      rtData
);

    logic [31:0] regs [32];
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [4:0]  rdAddr;
    logic [4:0]  writeAddr;

    assign rsAddr    = inst[25:21];
    assign rtAddr    = inst[20:16];
    assign rdAddr    = inst[15:11];
    assign writeAddr = ctrl.regDst ? rdAddr : rtAddr;

    // register zero is never written, so it keeps the value from reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

/* design/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import mipsPkg::*; (
    input  wire logic [31:0] inst,
    input  wire ctrlT        ctrl,
    input  wire logic [31:0] rsData,
    input  wire logic [31:0] rtData,
    output logic [31:0]      aluResult,
    output logic             zero
);

    logic [15:0] imm16;
    logic [31:0] imm32;
    logic [31:0] opB;

    assign imm16 = inst[15:0];

    // ori takes the immediate as unsigned, all the others sign-extend
    assign imm32 = ctrl.zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    assign opB   = ctrl.aluSrc ? imm32 : rtData;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluResult = rsData + opB;
            ALU_SUB: aluResult = rsData - opB;
            ALU_AND: aluResult = rsData & opB;
            ALU_OR:  aluResult = rsData | opB;
            ALU_SLT: aluResult = {31'd0, $signed(rsData) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == 32'd0);

endmodule

`default_nettype wire

/* design/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire ctrlT        ctrl,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] writeData,
    output logic [31:0]      readData
);

    logic [31:0] mem [DMEM_DEPTH];
    logic [5:0]  wordIdx;

    // only word accesses exist, higher address bits wrap around
    assign wordIdx = addr[7:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.memWrite) begin
            mem[wordIdx] <= writeData;
        end
    end

    assign readData = mem[wordIdx];

endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire imemLoadT imemLoad,
    output logic [31:0]   pc,
    output regCommitT     regCommit,
    output memCommitT     memCommit
);

    logic [31:0] inst;
    ctrlT        ctrl;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] memReadData;
    logic [31:0] writeBack;
    logic [4:0]  destAddr;

    // ########################################
    // datapath
    // ########################################

    pcUnit uPc (
        .clk(clk),
        .rstN(rstN),
        .inst(inst),
        .ctrl(ctrl),
        .zero(zero),
        .pc(pc)
    );

    instrMem uImem (.clk(clk), .imemLoad(imemLoad), .pc(pc), .inst(inst));

    controlDecode uDecode (.inst(inst), .ctrl(ctrl));

    regFile uRegs (
        .clk(clk),
        .rstN(rstN),
        .inst(inst),
        .ctrl(ctrl),
        .writeData(writeBack),
        .rsData(rsData),
        .rtData(rtData)
    );

    execUnit uExec (
        .inst(inst),
        .ctrl(ctrl),
        .rsData(rsData),
        .rtData(rtData),
        .aluResult(aluResult),
        .zero(zero)
    );

    dataMem uDmem (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .addr(aluResult),
        .writeData(rtData),
        .readData(memReadData)
    );

    assign writeBack = ctrl.memToReg ? memReadData : aluResult;

    // ########################################
    // commit reports
    // ########################################

    // the same destination the register file picks; r0 writes are dropped
    assign destAddr = ctrl.regDst ? inst[15:11] : inst[20:16];

    assign regCommit.en   = rstN && ctrl.regWrite && (destAddr != 5'd0);
    assign regCommit.addr = destAddr;
    assign regCommit.data = writeBack;

    assign memCommit.en   = rstN && ctrl.memWrite;
    assign memCommit.addr = aluResult;
    assign memCommit.data = rtData;

endmodule

`default_nettype wire

/* sim/mipsCore_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreSva import mipsPkg::*; (
    input wire logic        clk,
    input wire logic        rstN,
    input wire logic [31:0] pc,
    input wire regCommitT   regCommit,
    input wire memCommitT   memCommit
);

    int resetFails = 0;
    int alignFails = 0;
    int unknownFails = 0;
    int failCount;

    assign failCount = resetFails + alignFails + unknownFails;

    noCommitInReset: assert property (@(posedge clk) !rstN |-> !regCommit.en && !memCommit.en)
        else begin
            $error("commit enable high while the core is held in reset");
            resetFails++;
        end

    pcWordAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            alignFails++;
        end

    pcKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(pc))
        else begin
            $error("pc has unknown bits after reset");
            unknownFails++;
        end

endmodule

bind mipsCore mipsCoreSva uSva (
    .clk(clk),
    .rstN(rstN),
    .pc(pc),
    .regCommit(regCommit),
    .memCommit(memCommit)
);

`default_nettype wire

/* sim/mipsChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsChecker import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire imemLoadT    imemLoad,
    input  wire logic [31:0] pc,
    input  wire regCommitT   regCommit,
    input  wire memCommitT   memCommit,
    output int               errorCount,
    output int               checkCount
);

    logic [31:0] prog [IMEM_DEPTH];
    logic [31:0] regs [32];
    logic [31:0] dmem [DMEM_DEPTH];
    logic [31:0] modelPc;
    int errors = 0;
    int checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // the model keeps its own copy of whatever goes through the load port
    always @(posedge clk) begin
        if (imemLoad.en) begin
            prog[imemLoad.addr] = imemLoad.data;
        end
    end

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic holdReset();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = '0;
        end
        modelPc = '0;
        compareField("pc", 32'd0, pc);
        compareField("regCommit.en", 32'd0, 32'(regCommit.en));
        compareField("memCommit.en", 32'd0, 32'(memCommit.en));
    endtask

    // ########################################
    // instruction-set model, one instruction per cycle
    // ########################################

    task automatic stepModel();
        logic [31:0] inst;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] result;
        logic [31:0] memAddr;
        logic [31:0] nextPc;
        logic [4:0]  dest;
        logic        regWr;
        logic        memWr;

        inst    = prog[modelPc[9:2]];
        sImm    = {{16{inst[15]}}, inst[15:0]};
        zImm    = {16'h0000, inst[15:0]};
        opA     = regs[inst[25:21]];
        opB     = regs[inst[20:16]];
        memAddr = opA + sImm;
        nextPc  = modelPc + 32'd4;
        result  = '0;
        dest    = inst[20:16];
        regWr   = 1'b0;
        memWr   = 1'b0;
        case (inst[31:26])
            OP_RTYPE: begin
                dest  = inst[15:11];
                regWr = 1'b1;
                case (inst[5:0])
                    FN_ADDU: result = opA + opB;
                    FN_SUBU: result = opA - opB;
                    FN_AND:  result = opA & opB;
                    FN_OR:   result = opA | opB;
                    FN_SLT:  result = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                    default: regWr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                regWr  = 1'b1;
                result = opA + sImm;
            end
            OP_ORI: begin
                regWr  = 1'b1;
                result = opA | zImm;
            end
            OP_LW: begin
                regWr  = 1'b1;
                result = dmem[memAddr[7:2]];
            end
            OP_SW: memWr = 1'b1;
            OP_BEQ: begin
                if (opA == opB) begin
                    nextPc = nextPc + {sImm[29:0], 2'b00};
                end
            end
            OP_J: nextPc = {nextPc[31:28], inst[25:0], 2'b00};
            default: begin
            end
        endcase

        // a write to r0 is no write at all
        regWr = regWr && (dest != 5'd0);

        compareField("pc", modelPc, pc);
        compareField("regCommit.en", 32'(regWr), 32'(regCommit.en));
        if (regWr) begin
            compareField("regCommit.addr", 32'(dest), 32'(regCommit.addr));
            compareField("regCommit.data", result, regCommit.data);
            regs[dest] = result;
        end
        compareField("memCommit.en", 32'(memWr), 32'(memCommit.en));
        if (memWr) begin
            compareField("memCommit.addr", memAddr, memCommit.addr);
            compareField("memCommit.data", opB, memCommit.data);
            dmem[memAddr[7:2]] = opB;
        end
        modelPc = nextPc;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rstN) begin
            holdReset();
        end else begin
            stepModel();
        end
    end

endmodule

`default_nettype wire

/* sim/tbMips.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMips import mipsPkg::*; ();

    localparam int NUM_TESTS = 4;
    localparam int MAX_WORDS = 200;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES = 400;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (MAX_WORDS + RESET_CYCLES + RUN_CYCLES) * 11 / 10;
    localparam logic [31:0] LFSR_SEED = 32'h22b5d51c;

    logic        clk = 1'b0;
    logic        rstN;
    imemLoadT    imemLoad;
    logic [31:0] pc;
    regCommitT   regCommit;
    memCommitT   memCommit;
    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    logic [31:0] lfsrState = LFSR_SEED;
    logic [31:0] prog [IMEM_DEPTH];

    always #2 clk = ~clk;

    mipsCore UUT (
        .clk(clk),
        .rstN(rstN),
        .imemLoad(imemLoad),
        .pc(pc),
        .regCommit(regCommit),
        .memCommit(memCommit)
    );

    mipsChecker uCheck (
        .clk(clk),
        .rstN(rstN),
        .imemLoad(imemLoad),
        .pc(pc),
        .regCommit(regCommit),
        .memCommit(memCommit),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // ########################################
    // random program generation
    // ########################################

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [5:0] pickFunct();
        logic [31:0] sel;
        sel = randBits(3) % 32'd5;
        case (sel)
            32'd0:   return FN_ADDU;
            32'd1:   return FN_SUBU;
            32'd2:   return FN_AND;
            32'd3:   return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    // only registers 0 to 7 are used, so results feed each other often
    task automatic buildProgram(output int len);
        int kind;
        int maxOff;
        int off;
        int target;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;

        len = 40 + int'(randBits(8) % 32'(MAX_WORDS - 39));
        for (int i = 0; i < len - 1; i++) begin
            kind = int'(randBits(4) % 32'd10);
            rs   = 5'(randBits(3));
            rt   = 5'(randBits(3));
            rd   = 5'(randBits(3));
            imm  = 16'(randBits(16));
            case (kind)
                0, 1, 2, 3: prog[i] = {OP_RTYPE, rs, rt, rd, 5'd0, pickFunct()};
                4: prog[i] = {OP_ADDIU, rs, rt, imm};
                5: prog[i] = {OP_ORI, rs, rt, imm};
                6: prog[i] = {OP_LW, 5'd0, rt, 8'd0, 6'(randBits(6)), 2'b00};
                7: prog[i] = {OP_SW, 5'd0, rt, 8'd0, 6'(randBits(6)), 2'b00};
                8: begin
                    maxOff = len - 2 - i;
                    off = int'(randBits(3));
                    if (off > maxOff) begin
                        off = maxOff;
                    end
                    prog[i] = {OP_BEQ, rs, rt, 16'(off)};
                end
                default: begin
                    target = i + 1 + int'(randBits(3));
                    if (target > len - 1) begin
                        target = len - 1;
                    end
                    prog[i] = {OP_J, 26'(target)};
                end
            endcase
        end
        prog[len - 1] = {OP_J, 26'(len - 1)};
    endtask

    // ########################################
    // test sequence
    // ########################################

    task automatic runTest(input int testIdx);
        int len;
        int errorsBefore;

        buildProgram(len);
        errorsBefore = errorCount;
        @(posedge clk);
        rstN     <= 1'b0;
        imemLoad <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int w = 0; w < len; w++) begin
            imemLoad <= '{en: 1'b1, addr: 8'(w), data: prog[w]};
            @(posedge clk);
        end
        imemLoad <= '0;
        @(posedge clk);
        rstN <= 1'b1;
        repeat (RUN_CYCLES) @(posedge clk);
        $display("test %0d finished: %0d words, %0d errors",
                 testIdx, len, errorCount - errorsBefore);
    endtask

    initial begin
        rstN     <= 1'b0;
        imemLoad <= '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("summary: %0d tests, %0d checks, %0d checker errors, %0d assertion failures",
                 NUM_TESTS, checkCount, errorCount, UUT.uSva.failCount);
        if (errorCount == 0 && UUT.uSva.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/mipsPkg.sv
design/pcUnit.sv
design/instrMem.sv
design/controlDecode.sv
design/regFile.sv
design/execUnit.sv
design/dataMem.sv
design/mipsCore.sv
sim/mipsCore_sva.sv
sim/mipsChecker.sv
sim/tbMips.sv

/* run.sh */
#!/usr/bin/env bash
# build the Verilator model, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tbMips -o simv \
    && ./obj_dir/simv +verilator+error+limit+1000 | tee sim.log \
    && grep -qx "Everything OK" sim.log \
    && echo "simulation passed, log in sim.log" \
    || { echo "simulation failed, log in sim.log"; exit 1; }
